// File: Makefile
# Verilator build and run for the Horner polynomial evaluator

VERILATOR ?= verilator
TOP       ?= poly_evaluator_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line appears in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
design/horner_pkg.sv
design/poly_coeff_rom.sv
design/fixed_multiplier.sv
design/saturating_adder.sv
design/coeff_index_counter.sv
design/horner_sequencer.sv
design/poly_evaluator_top.sv
tb/poly_evaluator_tb.sv

// File: design/coeff_index_counter.sv
`timescale 1ns/10ps
`default_nettype none

module coeff_index_counter (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         load,
    input  wire horner_pkg::poly_sel_t  sel,
    input  wire                         dec,
    output horner_pkg::coeff_idx_t      index,
    output logic                        is_zero
);
    import horner_pkg::*;

    // Starts at c_n, walks down to c0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else if (load) begin
            index <= poly_degree(sel);
        end else if (dec) begin
            index <= index - 1'b1;
        end
    end

    // Last coefficient reached
    assign is_zero = (index == '0);

    // Index never wraps below c0
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        dec |-> !is_zero);

endmodule

`default_nettype wire

// File: design/fixed_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module fixed_multiplier (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire horner_pkg::fix_t a,
    input  wire horner_pkg::fix_t b,
    output horner_pkg::fix_t      product,
    output logic                  sat,
    output logic                  done
);
    import horner_pkg::*;

    logic                    running;
    logic [4:0]              steps_left;
    logic                    neg;
    logic [fix_width-1:0]    mag_a;
    logic [fix_width-1:0]    mag_b;
    logic [2*fix_width-1:0]  mcand;
    logic [fix_width-1:0]    mplier;
    logic [2*fix_width-1:0]  acc;
    logic [2*fix_width-1:0]  partial;
    logic [2*fix_width-1:0]  acc_next;
    logic signed [2*fix_width-1:0] full_prod;
    logic signed [2*fix_width-1:0] shifted;

    // Magnitudes, fix_min maps to 2^31 unsigned
    assign mag_a = a[fix_width-1] ? -a : a;
    assign mag_b = b[fix_width-1] ? -b : b;

    // ====================
    // Radix-4 step
    // ====================
    always_comb begin
        case (mplier[1:0])
            2'd0:    partial = '0;
            2'd1:    partial = mcand;
            2'd2:    partial = mcand << 1;
            default: partial = mcand + (mcand << 1);
        endcase
        acc_next = acc + partial;
        // Sign applied before shift, so truncation is toward -inf
        full_prod = neg ? -$signed(acc_next) : $signed(acc_next);
        shifted   = full_prod >>> frac_bits;
    end

    // Sequencing, one load cycle then 16 steps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running    <= 1'b0;
            steps_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running    <= 1'b1;
                steps_left <= 5'(fix_width / 2);
            end else if (running) begin
                steps_left <= steps_left - 5'd1;
                if (steps_left == 5'd1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= {{fix_width{1'b0}}, mag_a};
            mplier <= mag_b;
            acc    <= '0;
            neg    <= a[fix_width-1] ^ b[fix_width-1];
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
            // Last step, format and clamp
            if (steps_left == 5'd1) begin
                if (shifted > fix_max) begin
                    product <= fix_max;
                    sat     <= 1'b1;
                end else if (shifted < fix_min) begin
                    product <= fix_min;
                    sat     <= 1'b1;
                end else begin
                    product <= shifted[fix_width-1:0];
                    sat     <= 1'b0;
                end
            end
        end
    end

    // No restart mid-operation
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        running |-> !start);

    // Single-cycle completion pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

endmodule

`default_nettype wire

// File: design/horner_pkg.sv
`default_nettype none

package horner_pkg;

    // ====================
    // Fixed-point format
    // ====================

    // Q2.30 signed data word
    localparam int fix_width = 32;
    localparam int frac_bits = 30;

    typedef logic signed [fix_width-1:0] fix_t;

    // Saturation limits
    localparam fix_t fix_max = {1'b0, {(fix_width-1){1'b1}}};
    localparam fix_t fix_min = {1'b1, {(fix_width-1){1'b0}}};

    // ====================
    // Polynomial select
    // ====================

    // Codes 2..15 are invalid
    typedef enum logic [3:0] {
        POLY_F2XM1 = 4'd0,
        POLY_LOG2  = 4'd1
    } poly_sel_t;

    // Highest supported degree, sets index width
    localparam logic [3:0] max_degree = 4'd7;

    typedef logic [$clog2(max_degree + 1)-1:0] coeff_idx_t;

    // 2^x - 1, c_k = (ln 2)^k / k!
    localparam fix_t F2XM1_COEFFS [0:6] = '{
        32'sd0,
        32'sd744261118,
        32'sd257941248,
        32'sd59597083,
        32'sd10327387,
        32'sd1431680,
        32'sd165394
    };

    // log2(1+x), c_k = (-1)^(k+1) / (k ln 2)
    localparam fix_t LOG2_COEFFS [0:7] = '{
        32'sd0,
        32'sd1549082005,
        -32'sd774541002,
        32'sd516360668,
        -32'sd387270501,
        32'sd309816401,
        -32'sd258180334,
        32'sd221297429
    };

    // Degree follows the table length, 0 for bad codes
    function automatic coeff_idx_t poly_degree(input poly_sel_t sel);
        case (sel)
            POLY_F2XM1: return coeff_idx_t'($size(F2XM1_COEFFS) - 1);
            POLY_LOG2:  return coeff_idx_t'($size(LOG2_COEFFS) - 1);
            default:    return '0;
        endcase
    endfunction

    // ====================
    // Request / response
    // ====================

    typedef struct packed {
        poly_sel_t sel;
        fix_t      x;
    } eval_req_t;

    typedef struct packed {
        fix_t result;
        logic error;
    } eval_rsp_t;

endpackage

`default_nettype wire

// File: design/horner_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module horner_sequencer (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            start,
    input  wire horner_pkg::eval_req_t     req,
    output logic                           busy,
    output logic                           done,
    output horner_pkg::eval_rsp_t          rsp,
    output horner_pkg::poly_sel_t          sel_q,
    output logic                           cnt_load,
    output logic                           cnt_dec,
    input  wire                            index_zero,
    input  wire horner_pkg::fix_t          coeff,
    input  wire                            sel_valid,
    output logic                           mul_start,
    output horner_pkg::fix_t               mul_a,
    output horner_pkg::fix_t               mul_b,
    input  wire horner_pkg::fix_t          mul_product,
    input  wire                            mul_sat,
    input  wire                            mul_done,
    output logic                           add_start,
    output horner_pkg::fix_t               add_a,
    output horner_pkg::fix_t               add_b,
    input  wire horner_pkg::fix_t          add_sum,
    input  wire                            add_ovf,
    input  wire                            add_done
);
    import horner_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_TOP,
        MULTIPLY,
        WAIT_MUL,
        ADD,
        WAIT_ADD,
        FINISH
    } state_t;

    state_t state;
    fix_t   acc;
    fix_t   x_q;
    logic   err;
    logic   accept;

    // Start only counts when idle
    assign accept = (state == IDLE) && start;
    assign busy   = (state != IDLE);

    // ====================
    // Unit control
    // ====================
    assign cnt_load  = accept;
    // Step down right after the product lands
    assign cnt_dec   = (state == WAIT_MUL) && mul_done;
    assign mul_start = (state == MULTIPLY);
    assign mul_a     = acc;
    assign mul_b     = x_q;
    assign add_start = (state == ADD);
    assign add_a     = acc;
    assign add_b     = coeff;

    // Request latch
    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q <= req.sel;
            x_q   <= req.x;
        end
    end

    // ====================
    // Main FSM
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            acc   <= '0;
            err   <= 1'b0;
            done  <= 1'b0;
            rsp   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        err   <= 1'b0;
                        state <= LOAD_TOP;
                    end
                end
                LOAD_TOP: begin
                    if (sel_valid) begin
                        // ROM now shows c_n
                        acc   <= coeff;
                        state <= MULTIPLY;
                    end else begin
                        rsp   <= '{result: '0, error: 1'b1};
                        done  <= 1'b1;
                        state <= FINISH;
                    end
                end
                MULTIPLY: begin
                    state <= WAIT_MUL;
                end
                WAIT_MUL: begin
                    if (mul_done) begin
                        acc   <= mul_product;
                        err   <= err | mul_sat;
                        state <= ADD;
                    end
                end
                ADD: begin
                    state <= WAIT_ADD;
                end
                WAIT_ADD: begin
                    if (add_done) begin
                        acc <= add_sum;
                        err <= err | add_ovf;
                        // c0 just added
                        if (index_zero) begin
                            rsp   <= '{result: add_sum, error: err | add_ovf};
                            done  <= 1'b1;
                            state <= FINISH;
                        end else begin
                            state <= MULTIPLY;
                        end
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Completion only from the last state
    a_done_in_finish: assert property (@(posedge clk) disable iff (reset)
        done |-> state == FINISH);

endmodule

`default_nettype wire

// File: design/poly_coeff_rom.sv
`timescale 1ns/10ps
`default_nettype none

module poly_coeff_rom (
    input  wire horner_pkg::poly_sel_t  sel,
    input  wire horner_pkg::coeff_idx_t index,
    output horner_pkg::fix_t            coeff,
    output logic                        sel_valid
);
    import horner_pkg::*;

    // Pure lookup, no clock
    always_comb begin
        coeff     = '0;
        sel_valid = 1'b0;
        case (sel)
            POLY_F2XM1: begin
                sel_valid = 1'b1;
                // Table is one entry short of the index range
                if (int'(index) < $size(F2XM1_COEFFS)) begin
                    coeff = F2XM1_COEFFS[index];
                end
            end
            POLY_LOG2: begin
                sel_valid = 1'b1;
                if (int'(index) < $size(LOG2_COEFFS)) begin
                    coeff = LOG2_COEFFS[index];
                end
            end
            default: begin
                // Bad selector gives zero
                coeff = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/poly_evaluator_top.sv
`timescale 1ns/10ps
`default_nettype none

module poly_evaluator_top (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire horner_pkg::eval_req_t req,
    output logic                       busy,
    output logic                       done,
    output horner_pkg::eval_rsp_t      rsp
);
    import horner_pkg::*;

    poly_sel_t  sel_q;
    logic       cnt_load;
    logic       cnt_dec;
    coeff_idx_t index;
    logic       index_zero;
    fix_t       coeff;
    logic       sel_valid;
    logic       mul_start;
    fix_t       mul_a;
    fix_t       mul_b;
    fix_t       mul_product;
    logic       mul_sat;
    logic       mul_done;
    logic       add_start;
    fix_t       add_a;
    fix_t       add_b;
    fix_t       add_sum;
    logic       add_ovf;
    logic       add_done;

    // ====================
    // Control
    // ====================
    horner_sequencer u_seq (
        .clk(clk), .reset(reset), .start(start), .req(req),
        .busy(busy), .done(done), .rsp(rsp), .sel_q(sel_q),
        .cnt_load(cnt_load), .cnt_dec(cnt_dec), .index_zero(index_zero),
        .coeff(coeff), .sel_valid(sel_valid),
        .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
        .mul_product(mul_product), .mul_sat(mul_sat), .mul_done(mul_done),
        .add_start(add_start), .add_a(add_a), .add_b(add_b),
        .add_sum(add_sum), .add_ovf(add_ovf), .add_done(add_done)
    );

    // Loads in the accept cycle, so it sees the incoming selector
    coeff_index_counter u_cnt (
        .clk(clk), .reset(reset), .load(cnt_load), .sel(req.sel),
        .dec(cnt_dec), .index(index), .is_zero(index_zero)
    );

    poly_coeff_rom u_rom (
        .sel(sel_q), .index(index), .coeff(coeff), .sel_valid(sel_valid)
    );

    // ====================
    // Arithmetic
    // ====================
    fixed_multiplier u_mul (
        .clk(clk), .reset(reset), .start(mul_start), .a(mul_a), .b(mul_b),
        .product(mul_product), .sat(mul_sat), .done(mul_done)
    );

    saturating_adder u_add (
        .clk(clk), .reset(reset), .start(add_start), .a(add_a), .b(add_b),
        .sum(add_sum), .ovf(add_ovf), .done(add_done)
    );

endmodule

`default_nettype wire

// File: design/saturating_adder.sv
`timescale 1ns/10ps
`default_nettype none

module saturating_adder (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire horner_pkg::fix_t a,
    input  wire horner_pkg::fix_t b,
    output horner_pkg::fix_t      sum,
    output logic                  ovf,
    output logic                  done
);
    import horner_pkg::*;

    // One guard bit, operands sign-extend
    logic signed [fix_width:0] wide_sum;

    assign wide_sum = a + b;

    // Clamp and register
    always_ff @(posedge clk) begin
        if (start) begin
            if (wide_sum > fix_max) begin
                sum <= fix_max;
                ovf <= 1'b1;
            end else if (wide_sum < fix_min) begin
                sum <= fix_min;
                ovf <= 1'b1;
            end else begin
                sum <= wide_sum[fix_width-1:0];
                ovf <= 1'b0;
            end
        end
    end

    // Result valid one cycle after start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

`default_nettype wire

// File: tb/poly_evaluator_tb.sv
`timescale 1ns/10ps
`default_nettype none

module poly_evaluator_tb;
    import horner_pkg::*;

    localparam int done_timeout   = 2000;
    localparam int random_count   = 60;
    localparam int watch_cycles   = 500;
    // Truncated LOG2 series lands about 0.096 above 1.0
    localparam int unit_tolerance = 1 << 27;
    localparam logic signed [63:0] wide_max = 64'sd2147483647;
    localparam logic signed [63:0] wide_min = -64'sd2147483648;

    logic      clk;
    logic      reset;
    logic      start;
    eval_req_t req;
    logic      busy;
    logic      done;
    eval_rsp_t rsp;

    int error_count;
    int check_count;
    int tests_passed;
    int tests_failed;
    int errors_at_test_start;

    poly_evaluator_top DUT (
        .clk(clk), .reset(reset), .start(start), .req(req),
        .busy(busy), .done(done), .rsp(rsp)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ====================
    // Reference model
    // ====================

    // c_k from the package tables, 0 past the end
    function automatic fix_t table_coeff(input logic [3:0] sel_code, input int k);
        fix_t c;
        c = '0;
        if (sel_code == 4'd0 && k < $size(F2XM1_COEFFS)) begin
            c = F2XM1_COEFFS[k];
        end else if (sel_code == 4'd1 && k < $size(LOG2_COEFFS)) begin
            c = LOG2_COEFFS[k];
        end
        return c;
    endfunction

    // Full signed product, floor shift by 30, clamp
    function automatic fix_t model_mul(input fix_t a, input fix_t b, output logic sat);
        logic signed [63:0] wa;
        logic signed [63:0] wb;
        logic signed [63:0] p;
        fix_t r;
        wa = a;
        wb = b;
        p = (wa * wb) >>> frac_bits;
        sat = 1'b1;
        if (p > wide_max) begin
            r = fix_max;
        end else if (p < wide_min) begin
            r = fix_min;
        end else begin
            r = p[31:0];
            sat = 1'b0;
        end
        return r;
    endfunction

    // 33-bit sum, clamp
    function automatic fix_t model_add(input fix_t a, input fix_t b, output logic ovf);
        logic signed [32:0] wa;
        logic signed [32:0] wb;
        logic signed [32:0] w;
        fix_t r;
        wa = a;
        wb = b;
        w = wa + wb;
        ovf = 1'b1;
        if (w > 33'sh0_7fff_ffff) begin
            r = fix_max;
        end else if (w < -33'sh0_8000_0000) begin
            r = fix_min;
        end else begin
            r = w[31:0];
            ovf = 1'b0;
        end
        return r;
    endfunction

    // Horner from c_n down to c0, sticky error
    function automatic eval_rsp_t evaluate_model(input logic [3:0] sel_code, input fix_t x);
        eval_rsp_t r;
        fix_t acc;
        logic err;
        logic flag;
        int n;
        int k;
        r.result = '0;
        r.error  = 1'b1;
        if (sel_code > 4'd1) begin
            return r;
        end
        n = int'(poly_degree(poly_sel_t'(sel_code)));
        acc = table_coeff(sel_code, n);
        err = 1'b0;
        for (k = n - 1; k >= 0; k--) begin
            acc = model_mul(acc, x, flag);
            err = err | flag;
            acc = model_add(acc, table_coeff(sel_code, k), flag);
            err = err | flag;
        end
        r.result = acc;
        r.error  = err;
        return r;
    endfunction

    function automatic eval_req_t make_req(input logic [3:0] sel_code, input fix_t x);
        eval_req_t r;
        r.sel = poly_sel_t'(sel_code);
        r.x   = x;
        return r;
    endfunction

    // ====================
    // Driver tasks
    // ====================

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL @ %0t ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    // FINISH still counts as busy
    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            error_count++;
            $display("%s: DUT still busy after %0d cycles", name, done_timeout);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic pulse_start(input eval_req_t r);
        req   = r;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input string name, output eval_rsp_t r, output logic seen);
        int cycles;
        seen   = 1'b0;
        r      = '0;
        cycles = 0;
        while (!seen && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
                r    = rsp;
            end
        end
        if (!seen) begin
            error_count++;
            $display("%s: timed out, done never arrived within %0d cycles",
                     name, done_timeout);
        end
    endtask

    task automatic run_eval(input string name, input eval_req_t r,
                            output eval_rsp_t result, output logic seen);
        wait_idle(name);
        pulse_start(r);
        wait_done(name, result, seen);
    endtask

    task automatic eval_and_compare(input string name, input logic [3:0] sel_code,
                                    input fix_t x, output eval_rsp_t got);
        eval_rsp_t exp;
        logic seen;
        exp = evaluate_model(sel_code, x);
        run_eval(name, make_req(sel_code, x), got, seen);
        if (seen) begin
            check_value($sformatf("%s result", name), got.result, exp.result);
            check_value($sformatf("%s error", name), 32'(got.error), 32'(exp.error));
        end
    endtask

    task automatic begin_test();
        errors_at_test_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_test_start) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name,
                     error_count - errors_at_test_start);
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    // Horner collapses to c0, which is zero for both
    task automatic zero_input_test();
        eval_rsp_t got;
        logic seen;
        begin_test();
        run_eval("zero_input f2xm1", make_req(4'd0, '0), got, seen);
        if (seen) begin
            check_value("zero_input f2xm1 result", got.result, 32'd0);
            check_value("zero_input f2xm1 error", 32'(got.error), 32'd0);
        end
        run_eval("zero_input log2", make_req(4'd1, '0), got, seen);
        if (seen) begin
            check_value("zero_input log2 result", got.result, 32'd0);
            check_value("zero_input log2 error", 32'(got.error), 32'd0);
        end
        end_test("zero_input");
    endtask

    task automatic unit_input_test();
        eval_rsp_t got;
        int diff;
        logic [3:0] code;
        begin_test();
        for (code = 4'd0; code <= 4'd1; code++) begin
            eval_and_compare($sformatf("unit_input sel %0d", code), code,
                             32'sh4000_0000, got);
            // Sum of coefficients sits near 1.0
            diff = int'(got.result) - 32'sh4000_0000;
            check_value($sformatf("unit_input sel %0d near one", code),
                        32'(diff < unit_tolerance && diff > -unit_tolerance), 32'd1);
        end
        end_test("unit_input");
    endtask

    task automatic random_input_test();
        eval_rsp_t got;
        logic [31:0] raw;
        fix_t x;
        int i;
        begin_test();
        for (i = 0; i < random_count; i++) begin
            raw = $urandom;
            // Halving gives -1.0 up to just below 1.0
            x = $signed(raw) >>> 1;
            eval_and_compare($sformatf("random %0d f2xm1", i), 4'd0, x, got);
            eval_and_compare($sformatf("random %0d log2", i), 4'd1, x, got);
        end
        end_test("random_input");
    endtask

    task automatic invalid_select_test();
        eval_rsp_t got;
        begin_test();
        eval_and_compare("invalid sel 2", 4'd2, 32'sh2000_0000, got);
        check_value("invalid sel 2 zero result", got.result, 32'd0);
        check_value("invalid sel 2 error set", 32'(got.error), 32'd1);
        eval_and_compare("invalid sel 15", 4'd15, 32'sh2000_0000, got);
        check_value("invalid sel 15 zero result", got.result, 32'd0);
        check_value("invalid sel 15 error set", 32'(got.error), 32'd1);
        end_test("invalid_select");
    endtask

    // Both ends of the range blow up the LOG2 series
    task automatic saturation_test();
        eval_rsp_t got;
        begin_test();
        eval_and_compare("saturation near -2", 4'd1, 32'sh8000_0001, got);
        check_value("saturation near -2 error set", 32'(got.error), 32'd1);
        eval_and_compare("saturation near +2", 4'd1, fix_max, got);
        check_value("saturation near +2 error set", 32'(got.error), 32'd1);
        end_test("saturation");
    endtask

    task automatic start_while_busy_test();
        eval_rsp_t got;
        eval_rsp_t exp;
        eval_req_t first;
        eval_req_t second;
        logic seen;
        int extra;
        int i;
        begin_test();
        first  = make_req(4'd1, 32'sh2000_0000);
        second = make_req(4'd0, -32'sh1000_0000);
        exp    = evaluate_model(4'd1, 32'sh2000_0000);
        wait_idle("start_while_busy");
        pulse_start(first);
        repeat (5) @(negedge clk);
        check_value("start_while_busy busy", 32'(busy), 32'd1);
        // Must be dropped
        pulse_start(second);
        wait_done("start_while_busy", got, seen);
        if (seen) begin
            check_value("start_while_busy result", got.result, exp.result);
            check_value("start_while_busy error", 32'(got.error), 32'(exp.error));
        end
        // Long enough for a stray F2XM1 run to finish
        extra = 0;
        for (i = 0; i < watch_cycles; i++) begin
            @(negedge clk);
            if (done) begin
                extra++;
            end
        end
        check_value("start_while_busy extra done pulses", 32'(extra), 32'd0);
        end_test("start_while_busy");
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        error_count  = 0;
        check_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        errors_at_test_start = 0;
        reset = 1'b1;
        start = 1'b0;
        req   = '0;
        void'($urandom(83));
        // Reset for 10 clocks
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        zero_input_test();
        unit_input_test();
        random_input_test();
        invalid_select_test();
        saturation_test();
        start_while_busy_test();

        $display("Tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
